/* hdl/lcd_pkg.sv */
package lcd_pkg;

    localparam int LCD_COLS        = 16;
    localparam int HEX_DIGITS      = 8;
    localparam int POWERUP_PERIODS = 10;  // Strobe periods before the first command

    // Driver sequencing
    localparam int INIT_CMDS     = 5;
    localparam int REFRESH_STEPS = 2 * LCD_COLS + 2;  // Two addresses plus two rows

    typedef logic [7:0] lcd_char_t;

    // Column 0 in the top byte
    typedef logic [LCD_COLS*8-1:0] lcd_row_t;

    localparam lcd_char_t CHAR_SPACE = 8'h20;

    // HD44780 commands
    localparam lcd_char_t CMD_FUNCTION_SET = 8'h38;  // 8-bit bus, 2 lines, 5x7
    localparam lcd_char_t CMD_DISP_OFF     = 8'h08;
    localparam lcd_char_t CMD_CLEAR        = 8'h01;
    localparam lcd_char_t CMD_ENTRY_MODE   = 8'h06;
    localparam lcd_char_t CMD_DISP_ON      = 8'h0C;  // No cursor
    localparam lcd_char_t CMD_ROW1_ADDR    = 8'h80;
    localparam lcd_char_t CMD_ROW2_ADDR    = 8'hC0;

    typedef struct packed {
        lcd_row_t row_1;
        lcd_row_t row_2;
    } lcd_frame_t;

    // One character write into the frame store
    typedef struct packed {
        logic      en;
        logic      row;   // 0 is the first row
        logic [3:0] col;
        lcd_char_t ch;
    } char_wr_t;

    typedef struct packed {
        logic        row;
        logic        half;   // 1 selects columns 8 to 15
        logic [31:0] value;
    } hex_req_t;

    // LCD pins, R/W is tied low on the board
    typedef struct packed {
        logic      en;
        logic      rs;
        lcd_char_t data;
    } lcd_bus_t;

endpackage

/* hdl/hex_text_writer.sv */
`timescale 1ns/10ps

module hex_text_writer (
    input  logic              clk,
    input  logic              rst,
    input  logic              load,
    input  lcd_pkg::hex_req_t req,
    output logic              busy,
    output lcd_pkg::char_wr_t wr
);
    import lcd_pkg::*;

    logic        row_q;
    logic        half_q;
    logic [2:0]  col_cnt;
    logic [31:0] value_q;

    function automatic lcd_char_t hex_ascii(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return 8'h30 + {4'h0, nib};
        end
        return 8'h37 + {4'h0, nib};  // Upper case A to F
    endfunction

    // Busy runs while the column counter steps through eight digits
    always_ff @(posedge clk) begin
        if (!rst) begin
            busy    <= 1'b0;
            col_cnt <= 3'd0;
        end else if (busy) begin
            col_cnt <= col_cnt + 3'd1;
            if (col_cnt == 3'(HEX_DIGITS - 1)) begin
                busy <= 1'b0;
            end
        end else if (load) begin
            busy    <= 1'b1;
            col_cnt <= 3'd0;
        end
    end

    // Request capture, then one nibble out per cycle
    always_ff @(posedge clk) begin
        if (!busy && load) begin
            row_q   <= req.row;
            half_q  <= req.half;
            value_q <= req.value;
        end else if (busy) begin
            value_q <= {value_q[27:0], 4'h0};
        end
    end

    always_comb begin
        wr.en  = busy;
        wr.row = row_q;
        wr.col = {half_q, col_cnt};            // Half picks column 0 or 8
        wr.ch  = hex_ascii(value_q[31:28]);    // Most significant nibble first
    end

endmodule

/* hdl/frame_buffer.sv */
`timescale 1ns/10ps

module frame_buffer (
    input  logic                clk,
    input  logic                rst,
    input  lcd_pkg::char_wr_t   wr,
    input  logic                frame_sync,
    output lcd_pkg::lcd_frame_t frame
);
    import lcd_pkg::*;

    lcd_frame_t back;
    lcd_frame_t back_next;
    lcd_frame_t front;

    // Column 0 sits in the top byte, so the byte index is the inverted column
    always_comb begin
        back_next = back;
        if (wr.en) begin
            if (wr.row) begin
                back_next.row_2[{~wr.col, 3'b000} +: 8] = wr.ch;
            end else begin
                back_next.row_1[{~wr.col, 3'b000} +: 8] = wr.ch;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            back <= {(2 * LCD_COLS){CHAR_SPACE}};
        end else begin
            back <= back_next;
        end
    end

    // Commit at the start of a refresh pass, including a write on the same edge
    always_ff @(posedge clk) begin
        if (!rst) begin
            front <= {(2 * LCD_COLS){CHAR_SPACE}};
        end else if (frame_sync) begin
            front <= back_next;
        end
    end

    assign frame = front;

endmodule

/* hdl/lcd1602_driver.sv */
`timescale 1ns/10ps

module lcd1602_driver #(
    parameter int clk_div = 24_000
) (
    input  logic                clk,
    input  logic                rst,
    input  lcd_pkg::lcd_frame_t frame,
    output logic                frame_sync,
    output lcd_pkg::lcd_bus_t   lcd
);
    import lcd_pkg::*;

    logic [$clog2(POWERUP_PERIODS * clk_div)-1:0] pwr_cnt;
    logic [$clog2(clk_div)-1:0]                   period_cnt;
    logic                                         delay_done;
    logic                                         tick;

    logic      in_init;
    logic [5:0] step;
    logic      started;    // First byte is on the bus
    logic      rs_q;
    lcd_char_t data_q;

    logic      next_rs;
    lcd_char_t next_data;
    logic [3:0] char_col;
    lcd_row_t  char_row;

    assign delay_done = (pwr_cnt == POWERUP_PERIODS * clk_div - 1);

    // Power-up wait, holds at the last count
    always_ff @(posedge clk) begin
        if (!rst) begin
            pwr_cnt <= '0;
        end else if (!delay_done) begin
            pwr_cnt <= pwr_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            period_cnt <= '0;
        end else if (delay_done) begin
            if (period_cnt == clk_div - 1) begin
                period_cnt <= '0;
            end else begin
                period_cnt <= period_cnt + 1'b1;
            end
        end else begin
            period_cnt <= '0;
        end
    end

    assign tick = delay_done && (period_cnt == clk_div - 1);  // Period end, next byte loads

    assign frame_sync = tick && !in_init && (step == 6'd0);

    // Column and row for character steps
    always_comb begin
        if (step <= 6'(LCD_COLS)) begin
            char_col = 4'(step - 6'd1);
            char_row = frame.row_1;
        end else begin
            char_col = 4'(step - 6'(LCD_COLS + 2));
            char_row = frame.row_2;
        end
    end

    always_comb begin
        next_rs   = 1'b0;
        next_data = CMD_FUNCTION_SET;
        if (in_init) begin
            case (step[2:0])
                3'd0:    next_data = CMD_FUNCTION_SET;
                3'd1:    next_data = CMD_DISP_OFF;
                3'd2:    next_data = CMD_CLEAR;
                3'd3:    next_data = CMD_ENTRY_MODE;
                default: next_data = CMD_DISP_ON;
            endcase
        end else if (step == 6'd0) begin
            next_data = CMD_ROW1_ADDR;
        end else if (step == 6'(LCD_COLS + 1)) begin
            next_data = CMD_ROW2_ADDR;
        end else begin
            next_rs   = 1'b1;
            next_data = char_row[{~char_col, 3'b000} +: 8];
        end
    end

    // Step sequencer, init runs once and the refresh loop wraps
    always_ff @(posedge clk) begin
        if (!rst) begin
            in_init <= 1'b1;
            step    <= 6'd0;
            started <= 1'b0;
            rs_q    <= 1'b0;
            data_q  <= 8'h00;
        end else if (tick) begin
            started <= 1'b1;
            rs_q    <= next_rs;
            data_q  <= next_data;
            if (in_init) begin
                if (step == 6'(INIT_CMDS - 1)) begin
                    in_init <= 1'b0;
                    step    <= 6'd0;
                end else begin
                    step <= step + 6'd1;
                end
            end else if (step == 6'(REFRESH_STEPS - 1)) begin
                step <= 6'd0;
            end else begin
                step <= step + 6'd1;
            end
        end
    end

    // En high in the first half of each period, silent before the first byte
    always_comb begin
        lcd.en   = started && (period_cnt < clk_div / 2);
        lcd.rs   = rs_q;
        lcd.data = data_q;
    end

endmodule

/* hdl/lcd_display_top.sv */
`timescale 1ns/10ps

module lcd_display_top #(
    parameter int clk_div = 24_000  // Clock cycles per LCD strobe
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              load,
    input  lcd_pkg::hex_req_t req,
    output logic              busy,
    output lcd_pkg::lcd_bus_t lcd
);
    import lcd_pkg::*;

    char_wr_t   wr;
    lcd_frame_t frame;
    logic       frame_sync;

    hex_text_writer writer0 (
        .clk  (clk),
        .rst  (rst),
        .load (load),
        .req  (req),
        .busy (busy),
        .wr   (wr)
    );

    frame_buffer buffer0 (
        .clk        (clk),
        .rst        (rst),
        .wr         (wr),
        .frame_sync (frame_sync),
        .frame      (frame)
    );

    lcd1602_driver #(
        .clk_div (clk_div)
    ) driver0 (
        .clk        (clk),
        .rst        (rst),
        .frame      (frame),
        .frame_sync (frame_sync),
        .lcd        (lcd)
    );

endmodule

/* testbench/lcd_bus_monitor.sv */
`timescale 1ns/10ps

module lcd_bus_monitor (
    input  logic                rst,
    input  lcd_pkg::lcd_bus_t   lcd,
    output int                  byte_cnt,
    output logic                cap_rs,
    output lcd_pkg::lcd_char_t  cap_data,
    output int                  pass_cnt,
    output lcd_pkg::lcd_frame_t shown
);
    import lcd_pkg::*;

    lcd_frame_t building;  // Pass being collected
    logic       in_row_2;
    int         col;

    initial begin
        byte_cnt = 0;
        pass_cnt = 0;
        cap_rs   = 1'b0;
        cap_data = 8'h00;
        in_row_2 = 1'b0;
        col      = LCD_COLS;  // Ignore characters until the first address
        building = {(2 * LCD_COLS){CHAR_SPACE}};
        shown    = {(2 * LCD_COLS){CHAR_SPACE}};
    end

    // The LCD latches rs and data on the falling edge of en
    always @(negedge lcd.en) begin
        if (rst) begin
            cap_rs   = lcd.rs;
            cap_data = lcd.data;
            byte_cnt = byte_cnt + 1;
            if (!lcd.rs && lcd.data == CMD_ROW1_ADDR) begin
                in_row_2 = 1'b0;
                col      = 0;
            end else if (!lcd.rs && lcd.data == CMD_ROW2_ADDR) begin
                in_row_2 = 1'b1;
                col      = 0;
            end else if (lcd.rs && col < LCD_COLS) begin
                // Column 0 lands in the top byte
                if (in_row_2) begin
                    building.row_2[(LCD_COLS - 1 - col) * 8 +: 8] = lcd.data;
                end else begin
                    building.row_1[(LCD_COLS - 1 - col) * 8 +: 8] = lcd.data;
                end
                col = col + 1;
                if (in_row_2 && col == LCD_COLS) begin
                    shown    = building;
                    pass_cnt = pass_cnt + 1;  // Both rows complete
                end
            end
        end
    end

endmodule

/* testbench/tb_lcd_display.sv */
`timescale 1ns/10ps

module tb_lcd_display;
    import lcd_pkg::*;

    localparam int CLK_DIV       = 8;
    localparam int NUM_LOADS     = 40;
    localparam int PASS_LEN      = 2 * LCD_COLS + 2;
    localparam int BYTE_TIMEOUT  = 200;
    localparam int PASS_TIMEOUT  = 1200;
    localparam int IDLE_TIMEOUT  = 20;

    logic       clk;
    logic       rst;
    logic       load;
    hex_req_t   req;
    logic       busy;
    lcd_bus_t   lcd;
    int         byte_cnt;
    int         pass_cnt;
    logic       cap_rs;
    lcd_char_t  cap_data;
    lcd_frame_t shown;

    int          value_errs = 0;
    int          other_errs = 0;
    int          ignored = 0;   // Load attempts while busy
    logic [31:0] lfsr;

    // Reference model state
    logic       m_busy;
    int         m_cnt;
    hex_req_t   m_req;
    lcd_frame_t model_back;
    lcd_frame_t model_front;
    lcd_char_t  prev_data;

    lcd_display_top #(.clk_div(CLK_DIV)) dut0 (
        .clk  (clk),
        .rst  (rst),
        .load (load),
        .req  (req),
        .busy (busy),
        .lcd  (lcd)
    );

    lcd_bus_monitor mon0 (
        .rst      (rst),
        .lcd      (lcd),
        .byte_cnt (byte_cnt),
        .cap_rs   (cap_rs),
        .cap_data (cap_data),
        .pass_cnt (pass_cnt),
        .shown    (shown)
    );

    always #20 clk = ~clk;

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic lcd_char_t hex_digit(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return 8'h30 + nib;
        end
        return 8'h41 + (nib - 4'd10);
    endfunction

    function automatic lcd_char_t row_char(input lcd_row_t r, input int col);
        return r[(LCD_COLS - 1 - col) * 8 +: 8];
    endfunction

    function automatic lcd_char_t init_cmd(input int i);
        case (i)
            0:       return CMD_FUNCTION_SET;
            1:       return CMD_DISP_OFF;
            2:       return CMD_CLEAR;
            3:       return CMD_ENTRY_MODE;
            default: return CMD_DISP_ON;
        endcase
    endfunction

    task automatic finish_run();
        $display("Summary: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task automatic wait_next_byte(input int seen);
        int cycles;
        cycles = 0;
        while (byte_cnt == seen && cycles < BYTE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (byte_cnt == seen) begin
            other_errs++;
            $display("Timeout: no LCD byte was captured for %0d cycles", BYTE_TIMEOUT);
            finish_run();
        end
    endtask

    task automatic wait_passes(input int target);
        int cycles;
        cycles = 0;
        while (pass_cnt < target && cycles < PASS_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (pass_cnt < target) begin
            other_errs++;
            $display("Timeout: refresh pass %0d never completed", target);
            finish_run();
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy && cycles < IDLE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            other_errs++;
            $display("Timeout: busy stayed high after the last load");
            finish_run();
        end
    endtask

    // Writer rule, digit i of a load accepted at edge k lands at edge k+1+i
    always @(posedge clk) begin
        if (!rst) begin
            m_busy     = 1'b0;
            m_cnt      = 0;
            model_back = {(2 * LCD_COLS){CHAR_SPACE}};
        end else if (m_busy) begin
            if (m_req.row) begin
                model_back.row_2[(LCD_COLS - 1 - (m_req.half * 8 + m_cnt)) * 8 +: 8] =
                    hex_digit(4'(m_req.value >> (28 - 4 * m_cnt)));
            end else begin
                model_back.row_1[(LCD_COLS - 1 - (m_req.half * 8 + m_cnt)) * 8 +: 8] =
                    hex_digit(4'(m_req.value >> (28 - 4 * m_cnt)));
            end
            if (m_cnt == HEX_DIGITS - 1) begin
                m_busy = 1'b0;
            end
            m_cnt = m_cnt + 1;
            if (load) begin
                ignored++;
            end
        end else if (load) begin
            m_req  = req;
            m_busy = 1'b1;
            m_cnt  = 0;
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            model_front = {(2 * LCD_COLS){CHAR_SPACE}};
        end else begin
            assert (busy == m_busy) else begin
                value_errs++;
                $display("Error at %0t: busy got %0b expected %0b", $time, busy, m_busy);
            end
            if (lcd.data == CMD_ROW1_ADDR && prev_data !== CMD_ROW1_ADDR) begin
                model_front = model_back;  // Pass start
            end
        end
        prev_data = lcd.data;
    end

    initial begin : byte_checker
        int         seen;
        int         n;
        int         j;
        logic       exp_rs;
        lcd_char_t  exp_data;
        lcd_frame_t exp_frame;
        seen      = 0;
        n         = 0;
        exp_frame = {(2 * LCD_COLS){CHAR_SPACE}};
        forever begin
            wait_next_byte(seen);
            seen   = byte_cnt;
            exp_rs = 1'b0;
            if (n < 5) begin
                exp_data = init_cmd(n);
            end else begin
                j = (n - 5) % PASS_LEN;
                if (j == 0) begin
                    exp_frame = model_front;
                    exp_data  = CMD_ROW1_ADDR;
                end else if (j == LCD_COLS + 1) begin
                    exp_data = CMD_ROW2_ADDR;
                end else begin
                    exp_rs = 1'b1;
                    if (j <= LCD_COLS) begin
                        exp_data = row_char(exp_frame.row_1, j - 1);
                    end else begin
                        exp_data = row_char(exp_frame.row_2, j - LCD_COLS - 2);
                    end
                    if (n < 5 + PASS_LEN) begin
                        exp_data = CHAR_SPACE;  // First pass comes before any load
                    end
                end
            end
            assert (cap_rs == exp_rs && cap_data == exp_data) else begin
                value_errs++;
                $display("Error at %0t: lcd byte %0d got rs=%0b data=%h expected rs=%0b data=%h",
                         $time, n, cap_rs, cap_data, exp_rs, exp_data);
            end
            n++;
        end
    end

    initial begin
        logic [31:0] bits;
        logic [31:0] gap;
        clk  = 1'b0;
        rst  = 1'b0;
        load = 1'b0;
        req  = '0;
        lfsr = 32'hbb67_2467;
        repeat (4) @(posedge clk);
        #2 rst = 1'b1;

        // Bus stays silent through the power-up wait
        repeat (POWERUP_PERIODS * CLK_DIV) begin
            @(negedge clk);
            assert (lcd.en == 1'b0) else begin
                value_errs++;
                $display("Error at %0t: lcd.en got %0b expected 0", $time, lcd.en);
            end
        end
        wait_passes(1);

        for (int k = 0; k < NUM_LOADS; k++) begin
            @(posedge clk);
            #2;
            take_bits(1, bits);
            req.row = bits[0];
            take_bits(1, bits);
            req.half = bits[0];
            take_bits(32, bits);
            req.value = bits;
            take_bits(6, gap);
            load = 1'b1;
            @(posedge clk);
            #2 load = 1'b0;
            repeat (gap % 41) @(posedge clk);  // Short gaps land while busy
        end

        wait_idle();
        wait_passes(pass_cnt + 2);
        assert (shown == model_back) else begin
            value_errs++;
            $display("Error at %0t: shown frame got %h expected %h", $time, shown, model_back);
        end
        assert (ignored > 0) else begin
            other_errs++;
            $display("No load attempt fell while the writer was busy");
        end
        finish_run();
    end

endmodule

/* list.f */
hdl/lcd_pkg.sv
hdl/hex_text_writer.sv
hdl/frame_buffer.sv
hdl/lcd1602_driver.sv
hdl/lcd_display_top.sv
testbench/lcd_bus_monitor.sv
testbench/tb_lcd_display.sv

/* Bender.yml */
package:
  name: lcd_display

sources:
  - files:
      - hdl/lcd_pkg.sv
      - hdl/hex_text_writer.sv
      - hdl/frame_buffer.sv
      - hdl/lcd1602_driver.sv
      - hdl/lcd_display_top.sv
  - target: test
    files:
      - testbench/lcd_bus_monitor.sv
      - testbench/tb_lcd_display.sv
